// ==== usb_dev_pkg.sv ====
package usb_dev_pkg;

    typedef logic [3:0] btype_t;

    // ************************************************************
    // Packet types arriving from the device
    localparam btype_t BAG_DLINK = 4'b1000;
    localparam btype_t BAG_DTYPE = 4'b1001;
    localparam btype_t BAG_DTEMP = 4'b1010;
    localparam btype_t BAG_DATA0 = 4'b1101;
    localparam btype_t BAG_DATA1 = 4'b1110;
    localparam btype_t BAG_DATA  = 4'b0101;  // Expected read type for data packets

    // Packet types sent to the device
    localparam btype_t BAG_DIDX   = 4'b0101;
    localparam btype_t BAG_DPARAM = 4'b0110;
    localparam btype_t BAG_DDIDX  = 4'b0111;
    localparam btype_t BAG_LINK   = 4'b0100;
    localparam btype_t BAG_INIT   = 4'b0000;

    // Console command codes
    localparam btype_t BAG_DCONF = 4'b0001;
    localparam btype_t BAG_DCONV = 4'b1001;
    localparam btype_t BAG_CLINK = 4'b1011;

    // ************************************************************
    typedef enum logic [1:0] {
        NONE = 2'b00,
        T1   = 2'b01,
        T2   = 2'b10,
        T3   = 2'b11
    } dev_type_t;

    localparam logic [7:0] TYPE_T1_CODE = 8'hC0;
    localparam logic [7:0] TYPE_T2_CODE = 8'hF0;
    localparam logic [7:0] TYPE_T3_CODE = 8'hFF;

    localparam logic [3:0] LINK_T1 = 4'h8;
    localparam logic [3:0] LINK_T2 = 4'hC;
    localparam logic [3:0] LINK_T3 = 4'hF;

    // Status word field positions
    localparam int TEMP_LSB = 24;  // 8 bits
    localparam int TYPE_LSB = 16;  // 8 bits
    localparam int LINK_LSB = 12;  // 4 bits
    localparam int IDX_LSB  = 8;   // 4 bits
    localparam int DIDX_LSB = 4;   // 4 bits

endpackage

// ==== apb_console_pkg.sv ====
package apb_console_pkg;

    localparam int APB_AW = 4;

    // ************************************************************
    // Register offsets
    localparam logic [APB_AW-1:0] REG_CTRL = 4'h0;
    localparam logic [APB_AW-1:0] REG_CMD  = 4'h4;
    localparam logic [APB_AW-1:0] REG_STAT = 4'h8;

    // CTRL fields, all 4 bits wide
    localparam int CTRL_DEV_LSB  = 0;
    localparam int CTRL_DATA_LSB = 4;
    localparam int CTRL_RBT_LSB  = 8;

    // CMD fields
    localparam int CMD_COM_LSB = 0;   // 12 bits
    localparam int CMD_SBT_LSB = 12;  // 4 bits

    // STAT fields
    localparam int STAT_DEV_LSB  = 0;  // 10 bits
    localparam int STAT_BUSY_BIT = 16;
    localparam int STAT_RXV_BIT  = 17;

endpackage

// ==== console_usb_dev.sv ====
`timescale 1ns/1ns

module console_usb_dev (
    input  logic                clk,
    input  logic                rst,

    input  logic                fs_send,
    output logic                fd_send,
    output logic                fs_read,
    input  logic                fd_read,

    output logic                fs_usb_send,
    input  logic                fd_usb_send,
    input  logic                ff_usb_send,
    input  logic                fs_usb_read,
    output logic                fd_usb_read,

    input  usb_dev_pkg::btype_t send_btype,
    input  usb_dev_pkg::btype_t read_btype,
    output usb_dev_pkg::btype_t send_usb_btype,
    input  usb_dev_pkg::btype_t read_usb_btype,

    input  logic [3:0]          device_idx,
    input  logic [3:0]          data_idx,
    input  logic [11:0]         com_cmd,
    output logic [31:0]         usb_cmd,

    input  logic [31:0]         usb_stat,
    output logic [9:0]          dev_stat
);
    import usb_dev_pkg::*;

    typedef enum logic [11:0] {
        S_WAIT  = 12'h001,
        S_TAKE  = 12'h002,
        S_DISP  = 12'h004,
        S_LINK  = 12'h008,
        S_TYPE  = 12'h010,
        S_TEMP  = 12'h020,
        S_DATA  = 12'h040,
        S_READ  = 12'h080,
        S_CMD   = 12'h100,
        S_SEND  = 12'h200,
        S_SDONE = 12'h400,
        S_CDONE = 12'h800
    } state_t;

    state_t     state;
    state_t     next_state;
    logic       from_cmd;     // Current send was started by a console command
    logic       dev_link;
    dev_type_t  dev_type;
    logic [7:0] dev_temp;
    logic [7:0] usb_temp;
    logic [7:0] usb_type;
    logic [3:0] usb_link;
    logic [3:0] link_pat;

    assign usb_temp = usb_stat[TEMP_LSB +: 8];
    assign usb_type = usb_stat[TYPE_LSB +: 8];
    assign usb_link = usb_stat[LINK_LSB +: 4];

    assign fd_usb_read = (state == S_TAKE);
    assign fs_read     = (state == S_READ);
    assign fs_usb_send = (state == S_SEND);
    assign fd_send     = (state == S_CDONE);

    assign dev_stat = {(dev_link ? dev_type : NONE), dev_temp};

    // Without a known type every data packet passes the check
    always_comb begin
        case (dev_type)
            T1:      link_pat = LINK_T1;
            T2:      link_pat = LINK_T2;
            T3:      link_pat = LINK_T3;
            default: link_pat = usb_link;
        endcase
    end

    // ************************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_WAIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_WAIT: begin
                if (fs_usb_read) begin
                    next_state = S_TAKE;
                end else if (fs_send) begin
                    next_state = dev_link ? S_CMD : S_CDONE;  // Unlinked commands finish at once
                end
            end
            S_TAKE: begin
                if (!fs_usb_read) begin
                    next_state = S_DISP;
                end
            end
            S_DISP: begin
                case (read_usb_btype)
                    BAG_DLINK: next_state = S_LINK;
                    BAG_DTYPE: next_state = S_TYPE;
                    BAG_DTEMP: next_state = S_TEMP;
                    BAG_DATA0: next_state = S_DATA;
                    BAG_DATA1: next_state = S_DATA;
                    default:   next_state = S_WAIT;
                endcase
            end
            S_LINK: next_state = S_SEND;
            S_TYPE: next_state = S_WAIT;
            S_TEMP: next_state = S_READ;
            S_DATA: next_state = S_READ;
            S_READ: begin
                if (fd_read) begin
                    next_state = S_WAIT;
                end
            end
            S_CMD: begin
                case (send_btype)
                    BAG_DCONF: next_state = S_SEND;
                    BAG_DCONV: next_state = S_SEND;
                    BAG_CLINK: next_state = S_SEND;
                    default:   next_state = S_CDONE;
                endcase
            end
            S_SEND: begin
                if (fd_usb_send) begin
                    next_state = S_SDONE;
                end
            end
            S_SDONE: begin
                if (!fd_usb_send) begin
                    next_state = from_cmd ? S_CDONE : S_WAIT;
                end
            end
            S_CDONE: begin
                if (!fs_send) begin
                    next_state = S_WAIT;
                end
            end
            default: next_state = S_WAIT;
        endcase
    end

    // ************************************************************
    // Outgoing packet building
    always_ff @(posedge clk) begin
        if (state == S_LINK) begin
            usb_cmd        <= {device_idx, 28'h0};
            send_usb_btype <= BAG_DIDX;
        end else if (state == S_CMD) begin
            usb_cmd <= {device_idx, data_idx, com_cmd, 12'h000};
            case (send_btype)
                BAG_DCONF: send_usb_btype <= BAG_DPARAM;
                BAG_DCONV: send_usb_btype <= BAG_DDIDX;
                BAG_CLINK: send_usb_btype <= BAG_LINK;
                default:   send_usb_btype <= BAG_INIT;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            from_cmd <= 1'b0;
            dev_link <= 1'b0;
            dev_type <= NONE;
            dev_temp <= 8'h00;
        end else begin
            if (state == S_LINK) begin
                from_cmd <= 1'b0;
            end else if (state == S_CMD) begin
                from_cmd <= 1'b1;
            end

            if (ff_usb_send) begin
                dev_link <= 1'b0;  // Device stopped accepting packets
            end else if (state == S_LINK) begin
                dev_link <= 1'b1;
            end else if (state == S_TEMP && read_btype != BAG_DTEMP) begin
                dev_link <= 1'b0;
            end else if (state == S_DATA && usb_link != link_pat) begin
                dev_link <= 1'b0;
            end

            if (state == S_TYPE) begin
                case (usb_type)
                    TYPE_T1_CODE: dev_type <= T1;
                    TYPE_T2_CODE: dev_type <= T2;
                    TYPE_T3_CODE: dev_type <= T3;
                    default:      dev_type <= dev_type;
                endcase
            end

            if (state == S_TEMP) begin
                dev_temp <= usb_temp;
            end
        end
    end

endmodule

// ==== apb_console_regs.sv ====
`timescale 1ns/1ns

module apb_console_regs #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic [ADDR_WIDTH-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,

    output logic                  fs_send,
    output usb_dev_pkg::btype_t   send_btype,
    output logic [11:0]           com_cmd,
    output logic [3:0]            device_idx,
    output logic [3:0]            data_idx,
    output usb_dev_pkg::btype_t   read_btype,
    input  logic                  fd_send,

    input  logic                  fs_read,
    output logic                  fd_read,
    input  logic [9:0]            dev_stat
);
    import apb_console_pkg::*;

    logic wr_en;
    logic rd_en;
    logic cmd_wr;
    logic cmd_busy;
    logic rx_valid;
    logic fd_send_d;

    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign wr_en  = psel & penable & pwrite;
    assign rd_en  = psel & penable & ~pwrite;
    assign cmd_wr = wr_en & (paddr == ADDR_WIDTH'(REG_CMD)) & ~cmd_busy;  // Busy drops writes

    always_comb begin
        prdata = 32'h0;
        case (paddr)
            ADDR_WIDTH'(REG_CTRL): begin
                prdata[CTRL_DEV_LSB +: 4]  = device_idx;
                prdata[CTRL_DATA_LSB +: 4] = data_idx;
                prdata[CTRL_RBT_LSB +: 4]  = read_btype;
            end
            ADDR_WIDTH'(REG_CMD): begin
                prdata[CMD_COM_LSB +: 12] = com_cmd;
                prdata[CMD_SBT_LSB +: 4]  = send_btype;
            end
            ADDR_WIDTH'(REG_STAT): begin
                prdata[STAT_DEV_LSB +: 10] = dev_stat;
                prdata[STAT_BUSY_BIT]      = cmd_busy;
                prdata[STAT_RXV_BIT]       = rx_valid;
            end
            default: prdata = 32'h0;
        endcase
    end

    // ************************************************************
    always_ff @(posedge clk) begin
        if (cmd_wr) begin
            com_cmd    <= pwdata[CMD_COM_LSB +: 12];
            send_btype <= pwdata[CMD_SBT_LSB +: 4];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            device_idx <= 4'h0;
            data_idx   <= 4'h0;
            read_btype <= 4'h0;
            fs_send    <= 1'b0;
            cmd_busy   <= 1'b0;
            fd_send_d  <= 1'b0;
            fd_read    <= 1'b0;
            rx_valid   <= 1'b0;
        end else begin
            fd_send_d <= fd_send;
            if (wr_en && paddr == ADDR_WIDTH'(REG_CTRL)) begin
                device_idx <= pwdata[CTRL_DEV_LSB +: 4];
                data_idx   <= pwdata[CTRL_DATA_LSB +: 4];
                read_btype <= pwdata[CTRL_RBT_LSB +: 4];
            end

            if (cmd_wr) begin
                fs_send  <= 1'b1;
                cmd_busy <= 1'b1;
            end else begin
                if (fd_send) begin
                    fs_send <= 1'b0;
                end
                if (fd_send_d && !fd_send) begin
                    cmd_busy <= 1'b0;  // Controller closed the handshake
                end
            end

            fd_read <= fs_read;
            if (fs_read && !fd_read) begin
                rx_valid <= 1'b1;
            end else if (rd_en && paddr == ADDR_WIDTH'(REG_STAT)) begin
                rx_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== usb_packet_port.sv ====
`timescale 1ns/1ns

module usb_packet_port #(
    parameter int TX_TIMEOUT = 64
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                rx_valid_in,
    output logic                rx_ready,
    input  usb_dev_pkg::btype_t rx_btype,
    input  logic [31:0]         rx_stat,

    output logic                tx_valid,
    input  logic                tx_ready,
    output usb_dev_pkg::btype_t tx_btype,
    output logic [31:0]         tx_cmd,

    output logic                fs_usb_read,
    input  logic                fd_usb_read,
    output usb_dev_pkg::btype_t read_usb_btype,
    output logic [31:0]         usb_stat,
    input  logic                fs_usb_send,
    output logic                fd_usb_send,
    output logic                ff_usb_send,
    input  usb_dev_pkg::btype_t send_usb_btype,
    input  logic [31:0]         usb_cmd
);
    localparam int CNT_W = $clog2(TX_TIMEOUT + 1);

    logic             rx_full;
    logic             rx_acc;
    logic             tx_start;
    logic             tx_done;
    logic             tx_tmo;
    logic [CNT_W-1:0] tmo_cnt;

    assign rx_ready = ~rx_full;
    assign rx_acc   = rx_valid_in & rx_ready;

    assign tx_start = fs_usb_send & ~tx_valid & ~fd_usb_send;
    assign tx_done  = tx_valid & tx_ready;
    assign tx_tmo   = tx_valid & ~tx_ready & (tmo_cnt == CNT_W'(TX_TIMEOUT - 1));

    always_ff @(posedge clk) begin
        if (rx_acc) begin
            read_usb_btype <= rx_btype;
            usb_stat       <= rx_stat;
        end
        if (tx_start) begin
            tx_btype <= send_usb_btype;
            tx_cmd   <= usb_cmd;
        end
    end

    // ************************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_full     <= 1'b0;
            fs_usb_read <= 1'b0;
        end else if (rx_acc) begin
            rx_full     <= 1'b1;
            fs_usb_read <= 1'b1;  // Presented the cycle after acceptance
        end else if (fs_usb_read && fd_usb_read) begin
            fs_usb_read <= 1'b0;
        end else if (rx_full && !fs_usb_read && !fd_usb_read) begin
            rx_full <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_valid    <= 1'b0;
            fd_usb_send <= 1'b0;
            ff_usb_send <= 1'b0;
            tmo_cnt     <= '0;
        end else begin
            ff_usb_send <= tx_tmo;

            if (tx_start) begin
                tx_valid <= 1'b1;
            end else if (tx_done || tx_tmo) begin
                tx_valid <= 1'b0;
            end

            if (tx_done || tx_tmo) begin
                fd_usb_send <= 1'b1;  // Timeout still closes the handshake
            end else if (!fs_usb_send) begin
                fd_usb_send <= 1'b0;
            end

            if (!tx_valid || tx_ready) begin
                tmo_cnt <= '0;
            end else begin
                tmo_cnt <= tmo_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== usb_console_top.sv ====
`timescale 1ns/1ns

module usb_console_top #(
    parameter int TX_TIMEOUT = 64
) (
    input  logic                            clk,
    input  logic                            rst,

    input  logic [apb_console_pkg::APB_AW-1:0] paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,

    input  logic                            rx_valid_in,
    output logic                            rx_ready,
    input  usb_dev_pkg::btype_t             rx_btype,
    input  logic [31:0]                     rx_stat,

    output logic                            tx_valid,
    input  logic                            tx_ready,
    output usb_dev_pkg::btype_t             tx_btype,
    output logic [31:0]                     tx_cmd
);
    import usb_dev_pkg::*;
    import apb_console_pkg::*;

    // Console side
    logic        fs_send;
    logic        fd_send;
    logic        fs_read;
    logic        fd_read;
    btype_t      send_btype;
    btype_t      read_btype;
    logic [11:0] com_cmd;
    logic [3:0]  device_idx;
    logic [3:0]  data_idx;
    logic [9:0]  dev_stat;

    // USB side
    logic        fs_usb_read;
    logic        fd_usb_read;
    logic        fs_usb_send;
    logic        fd_usb_send;
    logic        ff_usb_send;
    btype_t      read_usb_btype;
    btype_t      send_usb_btype;
    logic [31:0] usb_stat;
    logic [31:0] usb_cmd;

    apb_console_regs #(
        .ADDR_WIDTH(APB_AW)
    ) apb_console_regs_i (
        .clk        (clk),
        .rst        (rst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .fs_send    (fs_send),
        .send_btype (send_btype),
        .com_cmd    (com_cmd),
        .device_idx (device_idx),
        .data_idx   (data_idx),
        .read_btype (read_btype),
        .fd_send    (fd_send),
        .fs_read    (fs_read),
        .fd_read    (fd_read),
        .dev_stat   (dev_stat)
    );

    console_usb_dev console_usb_dev_i (
        .clk            (clk),
        .rst            (rst),
        .fs_send        (fs_send),
        .fd_send        (fd_send),
        .fs_read        (fs_read),
        .fd_read        (fd_read),
        .fs_usb_send    (fs_usb_send),
        .fd_usb_send    (fd_usb_send),
        .ff_usb_send    (ff_usb_send),
        .fs_usb_read    (fs_usb_read),
        .fd_usb_read    (fd_usb_read),
        .send_btype     (send_btype),
        .read_btype     (read_btype),
        .send_usb_btype (send_usb_btype),
        .read_usb_btype (read_usb_btype),
        .device_idx     (device_idx),
        .data_idx       (data_idx),
        .com_cmd        (com_cmd),
        .usb_cmd        (usb_cmd),
        .usb_stat       (usb_stat),
        .dev_stat       (dev_stat)
    );

    usb_packet_port #(
        .TX_TIMEOUT(TX_TIMEOUT)
    ) usb_packet_port_i (
        .clk            (clk),
        .rst            (rst),
        .rx_valid_in    (rx_valid_in),
        .rx_ready       (rx_ready),
        .rx_btype       (rx_btype),
        .rx_stat        (rx_stat),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .tx_btype       (tx_btype),
        .tx_cmd         (tx_cmd),
        .fs_usb_read    (fs_usb_read),
        .fd_usb_read    (fd_usb_read),
        .read_usb_btype (read_usb_btype),
        .usb_stat       (usb_stat),
        .fs_usb_send    (fs_usb_send),
        .fd_usb_send    (fd_usb_send),
        .ff_usb_send    (ff_usb_send),
        .send_usb_btype (send_usb_btype),
        .usb_cmd        (usb_cmd)
    );

endmodule

// ==== tb_usb_console_tasks.svh ====
// ************************************************************
// APB access
task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    #2;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(posedge clk);  // Write lands at the end of the access phase
    #2;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
endtask

task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    #2;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    data = prdata;
    check_value("apb_read response", 32'h2, {30'h0, pready, pslverr});
    @(posedge clk);
    #2;
    psel = 1'b0;
    penable = 1'b0;
endtask

task automatic wait_stat_bit(input string test, input int pos, input logic level,
                             input string what, output logic [31:0] stat);
    int          n;
    logic [31:0] value;
    n = 0;
    apb_read(REG_STAT, value);
    while (value[pos] !== level && n < WAIT_LIMIT) begin
        apb_read(REG_STAT, value);
        n++;
    end
    stat = value;
    check_wait(test, value[pos] === level, what);
endtask

task automatic set_ctrl(input btype_t rbt);
    apb_write(REG_CTRL, {20'h0, rbt, cur_data_idx, cur_dev_idx});
endtask

task automatic run_command(input string test, input btype_t sbt, input logic [11:0] com);
    logic [31:0] stat;
    apb_write(REG_CMD, {16'h0, sbt, com});
    wait_stat_bit(test, STAT_BUSY_BIT, 1'b0, "cmd_busy clear", stat);
endtask

task automatic link_device(input string test);
    send_packet(BAG_DLINK, 32'h0);
    expect_packet(test, BAG_DIDX, {cur_dev_idx, 28'h0});  // Index packet carries only device_idx
endtask

task automatic decode_one(input logic [7:0] code, input logic [1:0] expected);
    logic [31:0] stat;
    send_packet(BAG_DTYPE, {8'h00, code, 16'h0});
    wait_rx_empty();
    apb_read(REG_STAT, stat);
    check_value("test_type_decode", 32'(expected), 32'(stat[9:8]));
endtask

// ************************************************************
// Directed tests
task automatic test_reset();
    logic [31:0] stat;
    apb_read(REG_STAT, stat);
    check_value("test_reset stat", 32'h0, stat);
    check_value("test_reset tx_valid", 32'h0, 32'(tx_valid));
endtask

task automatic test_link();
    cur_dev_idx = 4'hA;
    cur_data_idx = 4'h5;
    set_ctrl(BAG_DTEMP);
    link_device("test_link");
endtask

task automatic test_type_decode();
    decode_one(8'hC0, 2'b01);
    decode_one(8'hF0, 2'b10);
    decode_one(8'h3A, 2'b10);  // Unknown byte leaves the last type
    decode_one(8'hFF, 2'b11);
endtask

task automatic test_temperature();
    logic [7:0]  temp;
    logic [31:0] stat;
    temp = 8'(take_bits(8));
    set_ctrl(BAG_DTEMP);
    send_packet(BAG_DTEMP, {temp, 24'h0});
    wait_stat_bit("test_temperature", STAT_RXV_BIT, 1'b1, "rx_valid set", stat);
    check_value("test_temperature temp", 32'(temp), 32'(stat[7:0]));
    check_value("test_temperature type", 32'h3, 32'(stat[9:8]));
    temp = 8'(take_bits(8));
    set_ctrl(BAG_DTYPE);
    send_packet(BAG_DTEMP, {temp, 24'h0});
    wait_stat_bit("test_temperature", STAT_RXV_BIT, 1'b1, "rx_valid set", stat);
    check_value("test_temperature unlinked type", 32'h0, 32'(stat[9:8]));
endtask

task automatic test_commands();
    logic [11:0] com;
    link_device("test_commands link");
    com = 12'(take_bits(12));
    run_command("test_commands DCONF", BAG_DCONF, com);
    expect_packet("test_commands DCONF", BAG_DPARAM, {cur_dev_idx, cur_data_idx, com, 12'h000});
    com = 12'(take_bits(12));
    run_command("test_commands DCONV", BAG_DCONV, com);
    expect_packet("test_commands DCONV", BAG_DDIDX, {cur_dev_idx, cur_data_idx, com, 12'h000});
    com = 12'(take_bits(12));
    run_command("test_commands CLINK", BAG_CLINK, com);
    expect_packet("test_commands CLINK", BAG_LINK, {cur_dev_idx, cur_data_idx, com, 12'h000});
    run_command("test_commands unknown", 4'h2, com);
    check_value("test_commands unknown packets", 32'h0, 32'(tx_type_q.size()));
endtask

task automatic test_timeout();
    logic [31:0] stat;
    logic        dropped;
    int          high;
    int          n;
    @(posedge clk);
    #2;
    tx_ready = 1'b0;
    apb_write(REG_CMD, {16'h0, BAG_DCONF, 12'(take_bits(12))});
    n = 0;
    high = 0;
    dropped = 1'b0;
    while (!dropped && n < WAIT_LIMIT + 2 * TX_TIMEOUT) begin
        @(negedge clk);
        if (tx_valid) begin
            high++;
        end else if (high > 0) begin
            dropped = 1'b1;
        end
        n++;
    end
    check_wait("test_timeout", dropped, "tx_valid drop after the send timeout");
    assert (high >= TX_TIMEOUT) else begin
        $display("ERROR test_timeout hold: expected at least %0d, actual %0d", TX_TIMEOUT, high);
        value_errors++;
    end
    wait_stat_bit("test_timeout", STAT_BUSY_BIT, 1'b0, "cmd_busy clear", stat);
    check_value("test_timeout type", 32'h0, 32'(stat[9:8]));
    @(posedge clk);
    #2;
    tx_ready = 1'b1;
    run_command("test_timeout unlinked", BAG_DCONV, 12'(take_bits(12)));
    check_value("test_timeout unlinked packets", 32'h0, 32'(tx_type_q.size()));
endtask

task automatic test_data_check();
    logic [31:0] stat;
    link_device("test_data_check link");
    send_packet(BAG_DTYPE, {8'h00, 8'hF0, 16'h0});
    wait_rx_empty();
    send_packet(BAG_DATA0, {16'h0, 4'hC, 12'h0});  // Link pattern of a T2 device
    wait_stat_bit("test_data_check", STAT_RXV_BIT, 1'b1, "rx_valid set", stat);
    check_value("test_data_check match type", 32'h2, 32'(stat[9:8]));
    send_packet(BAG_DATA0, {16'h0, 4'h8, 12'h0});
    wait_stat_bit("test_data_check", STAT_RXV_BIT, 1'b1, "rx_valid set", stat);
    check_value("test_data_check mismatch type", 32'h0, 32'(stat[9:8]));
endtask

// ==== tb_usb_console.sv ====
`timescale 1ns/1ns

module tb_usb_console;
    import usb_dev_pkg::*;
    import apb_console_pkg::*;

    localparam int TX_TIMEOUT  = 64;
    localparam int CYCLE_LIMIT = 4000;  // About 400 cycles per exchange with margin
    localparam int WAIT_LIMIT  = 200;

    logic              clk;
    logic              rst;
    logic [APB_AW-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic              rx_valid_in;
    logic              rx_ready;
    btype_t            rx_btype;
    logic [31:0]       rx_stat;
    logic              tx_valid;
    logic              tx_ready;
    btype_t            tx_btype;
    logic [31:0]       tx_cmd;

    int                cycle_cnt;
    int                value_errors;
    int                wait_errors;
    logic [15:0]       lfsr_state;
    logic [3:0]        cur_dev_idx;
    logic [3:0]        cur_data_idx;
    btype_t            tx_type_q[$];
    logic [31:0]       tx_cmd_q[$];

    usb_console_top #(
        .TX_TIMEOUT(TX_TIMEOUT)
    ) usb_console_top_i (
        .clk         (clk),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .rx_valid_in (rx_valid_in),
        .rx_ready    (rx_ready),
        .rx_btype    (rx_btype),
        .rx_stat     (rx_stat),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .tx_btype    (tx_btype),
        .tx_cmd      (tx_cmd)
    );

    always #10 clk = ~clk;

    // Transmit packets taken by the device, sampled mid-cycle
    always @(negedge clk) begin
        if (tx_valid && tx_ready) begin
            tx_type_q.push_back(tx_btype);
            tx_cmd_q.push_back(tx_cmd);
        end
    end

    // ********************************************************
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11 + 1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit taken
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s: expected %h, actual %h", test, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_wait(input string test, input logic ok, input string what);
        assert (ok) else begin
            $display("%s: %s did not happen in time", test, what);
            wait_errors++;
        end
    endtask

    task automatic print_counts();
        $display("Error counts: %0d wrong values, %0d missed events", value_errors, wait_errors);
    endtask

    // Device model presents one packet and holds it until the port takes it
    task automatic send_packet(input btype_t btype, input logic [31:0] stat);
        int   n;
        logic taken;
        n = 0;
        taken = 1'b0;
        @(posedge clk);
        #2;
        rx_valid_in = 1'b1;
        rx_btype = btype;
        rx_stat = stat;
        while (!taken && n < WAIT_LIMIT) begin
            @(negedge clk);
            taken = rx_ready;
            @(posedge clk);
            n++;
        end
        #2;
        rx_valid_in = 1'b0;
        check_wait("send_packet", taken, "Packet acceptance");
    endtask

    task automatic wait_rx_empty();
        int   n;
        logic empty;
        n = 0;
        empty = 1'b0;
        while (!empty && n < WAIT_LIMIT) begin
            @(negedge clk);
            empty = rx_ready;
            n++;
        end
        check_wait("wait_rx_empty", empty, "Receive buffer release");
    endtask

    task automatic expect_packet(input string test, input btype_t btype, input logic [31:0] cmd);
        int n;
        n = 0;
        while (tx_type_q.size() == 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        check_wait(test, tx_type_q.size() > 0, "Transmit packet");
        if (tx_type_q.size() > 0) begin
            check_value({test, " type"}, 32'(btype), 32'(tx_type_q.pop_front()));
            check_value({test, " cmd"}, cmd, tx_cmd_q.pop_front());
        end
    endtask

`include "tb_usb_console_tasks.svh"

    // ********************************************************
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles before the tests were done", CYCLE_LIMIT);
            print_counts();
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 32'h0;
        rx_valid_in = 1'b0;
        rx_btype = 4'h0;
        rx_stat = 32'h0;
        tx_ready = 1'b1;
        cycle_cnt = 0;
        value_errors = 0;
        wait_errors = 0;
        lfsr_state = 16'd80;
        cur_dev_idx = 4'h0;
        cur_data_idx = 4'h0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        test_reset();
        test_link();
        test_type_decode();
        test_temperature();
        test_commands();
        test_timeout();
        test_data_check();

        print_counts();
        if (value_errors + wait_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
usb_dev_pkg.sv
apb_console_pkg.sv
console_usb_dev.sv
apb_console_regs.sv
usb_packet_port.sv
usb_console_top.sv
tb_usb_console.sv

// ==== Bender.yml ====
package:
  name: usb_console

sources:
  - usb_dev_pkg.sv
  - apb_console_pkg.sv
  - console_usb_dev.sv
  - apb_console_regs.sv
  - usb_packet_port.sv
  - usb_console_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_usb_console.sv
